// ==== hdl/trace_pkg.sv ====
// widths and buffer depth are fixed here for a 32-bit core with 32 GPRs; depth need not be 2^n

package trace_pkg;

    ////////////////////
    // sizes
    ////////////////////

    localparam int unsigned XLEN        = 32;                   // data and address width
    localparam int unsigned GLOG        = 5;                    // GPR index width, 32 regs
    localparam int unsigned TLEN        = 32;                   // timestamp counter width
    localparam int unsigned TRACE_DEPTH = 8;                    // records held in the buffer
    localparam int unsigned TRACE_ALOG  = $clog2(TRACE_DEPTH);  // buffer pointer width

    ////////////////////
    // trace record
    ////////////////////

    // one record per retired instruction
    typedef struct packed {
        logic [TLEN-1:0] tim;      // cycles since reset at push
        // fetch
        logic [XLEN-1:0] ifu_adr;  // PC
        logic [XLEN-1:0] ifu_ins;  // instruction word
        logic            ifu_siz;  // 1 - 32bit, 0 - 16bit
        logic            ifu_ill;  // all zeros or all ones
        // writeback
        logic            wbu_ena;  // GPR write happened
        logic [GLOG-1:0] wbu_idx;  // destination index
        logic [XLEN-1:0] wbu_dat;  // destination data
        // load/store
        logic            lsu_ena;  // transfer happened
        logic            lsu_wen;  // store when set, else load
        logic [GLOG-1:0] lsu_wid;  // store data source GPR
        logic [XLEN-1:0] lsu_adr;  // data address
        logic [     1:0] lsu_siz;  // logarithmic size
        logic [XLEN-1:0] lsu_wdt;  // store data
        logic [XLEN-1:0] lsu_rdt;  // load data
    } trace_rec_t;

endpackage : trace_pkg

// ==== hdl/tcb_mon_if.sv ====
// TCB-lite subset with fixed 1 cycle response latency; no clock inside, users get it as a port
`timescale 1ns/1ps

interface tcb_mon_if
    import trace_pkg::*;
();

    // handshake
    logic            vld;  // request valid
    logic            rdy;  // request ready
    // request
    logic            wen;  // write enable
    logic [XLEN-1:0] adr;  // address
    logic [     1:0] siz;  // logarithmic size, 0..3 -> 1..8 bytes
    logic [XLEN-1:0] wdt;  // write data
    // response, belongs to the transfer one cycle earlier
    logic [XLEN-1:0] rdt;  // read data

    // bus side, driven from the top level ports
    modport man (
        output vld,
        output rdy,
        output wen,
        output adr,
        output siz,
        output wdt,
        output rdt
    );

    // passive observer
    modport mon (
        input  vld,
        input  rdy,
        input  wen,
        input  adr,
        input  siz,
        input  wdt,
        input  rdt
    );

endinterface : tcb_mon_if

// ==== hdl/fetch_align.sv ====
// fetch outputs are valid only while ifp_ena is high; the word comes straight from the bus response
`timescale 1ns/1ps

module fetch_align
    import trace_pkg::*;
(
    input  logic            tcb_ifu,  // clock
    input  logic            rst_n,
    tcb_mon_if.mon          bus,      // instruction fetch bus
    output logic            ifp_ena,  // fetch response cycle
    output logic [XLEN-1:0] ifp_adr,  // address of that fetch
    output logic [XLEN-1:0] ifp_ins,  // instruction word
    output logic            ifp_siz,  // 32bit instruction
    output logic            ifp_ill   // trivially illegal word
);

    ////////////////////
    // request stage
    ////////////////////

    logic            trn;      // transfer this cycle
    logic            pnd;      // response due now
    logic [XLEN-1:0] adr_q;    // address held for the response

    assign trn = bus.vld & bus.rdy;

    always_ff @(posedge tcb_ifu or negedge rst_n) begin
        if (!rst_n) begin
            pnd <= 1'b0;
        end else begin
            pnd <= trn;
        end
    end

    // address held until its response
    always_ff @(posedge tcb_ifu) begin
        if (trn) begin
            adr_q <= bus.adr;
        end
    end

    ////////////////////
    // response stage
    ////////////////////

    assign ifp_ena = pnd;
    assign ifp_adr = adr_q;
    assign ifp_ins = bus.rdt;  // word of the previous transfer

    // RVC words have low bits != 2'b11
    assign ifp_siz = &bus.rdt[1:0];

    // all zeros and all ones are defined illegal
    assign ifp_ill = (bus.rdt == '0) | (bus.rdt == '1);

endmodule : fetch_align

// ==== hdl/lsu_align.sv ====
// one outstanding load/store at a time per cycle; read data taken unregistered from the response
`timescale 1ns/1ps

module lsu_align
    import trace_pkg::*;
(
    input  logic            tcb_ifu,  // clock
    input  logic            rst_n,
    tcb_mon_if.mon          bus,      // load/store bus
    input  logic [GLOG-1:0] gpr_sid,  // store data source GPR
    output logic            lsp_ena,  // response cycle of a transfer
    output logic            lsp_wen,  // store
    output logic [GLOG-1:0] lsp_wid,  // source index
    output logic [XLEN-1:0] lsp_adr,  // address
    output logic [     1:0] lsp_siz,  // logarithmic size
    output logic [XLEN-1:0] lsp_wdt,  // store data
    output logic [XLEN-1:0] lsp_rdt   // load data
);

    ////////////////////
    // request capture
    ////////////////////

    logic            trn;     // transfer this cycle
    logic            pnd;     // response cycle
    logic            wen_q;
    logic [GLOG-1:0] sid_q;
    logic [XLEN-1:0] adr_q;
    logic [     1:0] siz_q;
    logic [XLEN-1:0] wdt_q;

    assign trn = bus.vld & bus.rdy;

    // control
    always_ff @(posedge tcb_ifu or negedge rst_n) begin
        if (!rst_n) begin
            pnd <= 1'b0;
        end else begin
            pnd <= trn;
        end
    end

    // request payload, only meaningful while pnd
    always_ff @(posedge tcb_ifu) begin
        if (trn) begin
            wen_q <= bus.wen;
            sid_q <= gpr_sid;  // index seen alongside the request
            adr_q <= bus.adr;
            siz_q <= bus.siz;
            wdt_q <= bus.wdt;
        end
    end

    ////////////////////
    // paired output
    ////////////////////

    assign lsp_ena = pnd;
    assign lsp_wen = wen_q;
    assign lsp_wid = sid_q;
    assign lsp_adr = adr_q;
    assign lsp_siz = siz_q;
    assign lsp_wdt = wdt_q;
    assign lsp_rdt = bus.rdt;  // response to the held request

endmodule : lsu_align

// ==== hdl/trace_assemble.sv ====
// record is valid only while push is high; writeback and load/store parts are combinational
`timescale 1ns/1ps

module trace_assemble
    import trace_pkg::*;
(
    input  logic            tcb_ifu,  // clock
    input  logic            rst_n,
    // aligned fetch, cycle t+1
    input  logic            ifp_ena,
    input  logic [XLEN-1:0] ifp_adr,
    input  logic [XLEN-1:0] ifp_ins,
    input  logic            ifp_siz,
    input  logic            ifp_ill,
    // aligned load/store, cycle t+2
    input  logic            lsp_ena,
    input  logic            lsp_wen,
    input  logic [GLOG-1:0] lsp_wid,
    input  logic [XLEN-1:0] lsp_adr,
    input  logic [     1:0] lsp_siz,
    input  logic [XLEN-1:0] lsp_wdt,
    input  logic [XLEN-1:0] lsp_rdt,
    // GPR writeback, cycle t+2
    input  logic            gpr_den,
    input  logic [GLOG-1:0] gpr_did,
    input  logic [XLEN-1:0] gpr_ddt,
    // record out
    output logic            push,
    output trace_rec_t      rec
);

    ////////////////////
    // timestamp
    ////////////////////

    logic [TLEN-1:0] tim_cnt;  // 0 in first cycle after reset

    always_ff @(posedge tcb_ifu or negedge rst_n) begin
        if (!rst_n) begin
            tim_cnt <= '0;
        end else begin
            tim_cnt <= tim_cnt + 1'b1;  // wraps silently
        end
    end

    ////////////////////
    // fetch stage
    ////////////////////

    logic            ret;      // retire cycle
    logic [XLEN-1:0] ret_adr;
    logic [XLEN-1:0] ret_ins;
    logic            ret_siz;
    logic            ret_ill;

    always_ff @(posedge tcb_ifu or negedge rst_n) begin
        if (!rst_n) begin
            ret <= 1'b0;
        end else begin
            ret <= ifp_ena;
        end
    end

    always_ff @(posedge tcb_ifu) begin
        if (ifp_ena) begin
            ret_adr <= ifp_adr;
            ret_ins <= ifp_ins;  // word sampled during the response cycle
            ret_siz <= ifp_siz;
            ret_ill <= ifp_ill;
        end
    end

    ////////////////////
    // record
    ////////////////////

    assign push = ret;

    always_comb begin
        rec.tim     = tim_cnt;
        rec.ifu_adr = ret_adr;
        rec.ifu_ins = ret_ins;
        rec.ifu_siz = ret_siz;
        rec.ifu_ill = ret_ill;
        // writeback, zeroed when no write
        rec.wbu_ena = gpr_den;
        rec.wbu_idx = gpr_den ? gpr_did : '0;
        rec.wbu_dat = gpr_den ? gpr_ddt : '0;
        // load/store from t+1, zeroed when none
        rec.lsu_ena = lsp_ena;
        rec.lsu_wen = lsp_ena ? lsp_wen : 1'b0;
        rec.lsu_wid = lsp_ena ? lsp_wid : '0;
        rec.lsu_adr = lsp_ena ? lsp_adr : '0;
        rec.lsu_siz = lsp_ena ? lsp_siz : '0;
        rec.lsu_wdt = lsp_ena ? lsp_wdt : '0;
        rec.lsu_rdt = lsp_ena ? lsp_rdt : '0;
    end

endmodule : trace_assemble

// ==== hdl/trace_fifo.sv ====
// push on full is dropped unless a pop happens in the same cycle; ovf clears only on reset
`timescale 1ns/1ps

module trace_fifo
    import trace_pkg::*;
(
    input  logic       tcb_ifu,  // clock
    input  logic       rst_n,
    input  logic       push,     // write din
    input  trace_rec_t din,
    input  logic       pop,      // drops oldest unless empty
    output trace_rec_t dout,     // oldest record
    output logic       empty,
    output logic       ovf       // set once a record is lost
);

    ////////////////////
    // storage
    ////////////////////

    trace_rec_t            mem [TRACE_DEPTH];
    logic [TRACE_ALOG-1:0] wr_ptr;
    logic [TRACE_ALOG-1:0] rd_ptr;
    logic [TRACE_ALOG  :0] cnt;     // 0..TRACE_DEPTH
    logic                  full;
    logic                  do_push;
    logic                  do_pop;

    assign empty = (cnt == 0);
    assign full  = (cnt == (TRACE_ALOG+1)'(TRACE_DEPTH));

    assign do_pop  = pop & ~empty;
    assign do_push = push & (~full | do_pop);  // slot freed by same cycle pop

    // pointer increment wrapping at any depth
    function automatic logic [TRACE_ALOG-1:0] ptr_inc(input logic [TRACE_ALOG-1:0] ptr);
        ptr_inc = (ptr == TRACE_ALOG'(TRACE_DEPTH-1)) ? '0 : ptr + 1'b1;
    endfunction

    ////////////////////
    // control
    ////////////////////

    always_ff @(posedge tcb_ifu or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            cnt    <= '0;
            ovf    <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            // both or neither leaves count as is
            if (do_push & ~do_pop) begin
                cnt <= cnt + 1'b1;
            end else if (do_pop & ~do_push) begin
                cnt <= cnt - 1'b1;
            end
            if (push & ~do_push) begin
                ovf <= 1'b1;  // lost record
            end
        end
    end

    // payload array
    always_ff @(posedge tcb_ifu) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    assign dout = mem[rd_ptr];  // stale when empty

endmodule : trace_fifo

// ==== hdl/r5p_trace_top.sv ====
// passive recorder, both buses have 1 cycle response latency and the core is never stalled
`timescale 1ns/1ps

module r5p_trace_top
    import trace_pkg::*;
(
    input  logic            tcb_ifu,    // clock
    input  logic            rst_n,
    // instruction fetch bus
    input  logic            ifu_vld,
    input  logic            ifu_rdy,
    input  logic [XLEN-1:0] ifu_adr,
    input  logic [XLEN-1:0] ifu_rdt,
    // load/store bus
    input  logic            lsu_vld,
    input  logic            lsu_rdy,
    input  logic            lsu_wen,
    input  logic [XLEN-1:0] lsu_adr,
    input  logic [     1:0] lsu_siz,
    input  logic [XLEN-1:0] lsu_wdt,
    input  logic [XLEN-1:0] lsu_rdt,
    // GPR strobes
    input  logic            gpr_den,    // destination write
    input  logic [GLOG-1:0] gpr_did,
    input  logic [XLEN-1:0] gpr_ddt,
    input  logic [GLOG-1:0] gpr_sid,    // store source index
    // record reader
    input  logic            rec_pop,
    output logic            rec_empty,
    output trace_rec_t      rec_data,
    output logic            ovf
);

    ////////////////////
    // bus interfaces
    ////////////////////

    tcb_mon_if ifu_bus ();
    tcb_mon_if lsu_bus ();

    // fetch is read only, request payload tied off
    assign ifu_bus.vld = ifu_vld;
    assign ifu_bus.rdy = ifu_rdy;
    assign ifu_bus.wen = 1'b0;
    assign ifu_bus.adr = ifu_adr;
    assign ifu_bus.siz = 2'd2;     // always a word
    assign ifu_bus.wdt = '0;
    assign ifu_bus.rdt = ifu_rdt;

    assign lsu_bus.vld = lsu_vld;
    assign lsu_bus.rdy = lsu_rdy;
    assign lsu_bus.wen = lsu_wen;
    assign lsu_bus.adr = lsu_adr;
    assign lsu_bus.siz = lsu_siz;
    assign lsu_bus.wdt = lsu_wdt;
    assign lsu_bus.rdt = lsu_rdt;

    ////////////////////
    // alignment
    ////////////////////

    logic            ifp_ena;
    logic [XLEN-1:0] ifp_adr;
    logic [XLEN-1:0] ifp_ins;
    logic            ifp_siz;
    logic            ifp_ill;

    logic            lsp_ena;
    logic            lsp_wen;
    logic [GLOG-1:0] lsp_wid;
    logic [XLEN-1:0] lsp_adr;
    logic [     1:0] lsp_siz;
    logic [XLEN-1:0] lsp_wdt;
    logic [XLEN-1:0] lsp_rdt;

    fetch_align i_fetch (
        .tcb_ifu (tcb_ifu),
        .rst_n   (rst_n),
        .bus     (ifu_bus),
        .ifp_ena (ifp_ena),
        .ifp_adr (ifp_adr),
        .ifp_ins (ifp_ins),
        .ifp_siz (ifp_siz),
        .ifp_ill (ifp_ill)
    );

    lsu_align i_lsu (
        .tcb_ifu (tcb_ifu),
        .rst_n   (rst_n),
        .bus     (lsu_bus),
        .gpr_sid (gpr_sid),
        .lsp_ena (lsp_ena),
        .lsp_wen (lsp_wen),
        .lsp_wid (lsp_wid),
        .lsp_adr (lsp_adr),
        .lsp_siz (lsp_siz),
        .lsp_wdt (lsp_wdt),
        .lsp_rdt (lsp_rdt)
    );

    ////////////////////
    // record and buffer
    ////////////////////

    logic       push;
    trace_rec_t rec;

    trace_assemble i_asm (
        .tcb_ifu (tcb_ifu),
        .rst_n   (rst_n),
        .ifp_ena (ifp_ena),
        .ifp_adr (ifp_adr),
        .ifp_ins (ifp_ins),
        .ifp_siz (ifp_siz),
        .ifp_ill (ifp_ill),
        .lsp_ena (lsp_ena),
        .lsp_wen (lsp_wen),
        .lsp_wid (lsp_wid),
        .lsp_adr (lsp_adr),
        .lsp_siz (lsp_siz),
        .lsp_wdt (lsp_wdt),
        .lsp_rdt (lsp_rdt),
        .gpr_den (gpr_den),
        .gpr_did (gpr_did),
        .gpr_ddt (gpr_ddt),
        .push    (push),
        .rec     (rec)
    );

    trace_fifo i_fifo (
        .tcb_ifu (tcb_ifu),
        .rst_n   (rst_n),
        .push    (push),
        .din     (rec),
        .pop     (rec_pop),
        .dout    (rec_data),
        .empty   (rec_empty),
        .ovf     (ovf)
    );

endmodule : r5p_trace_top

// ==== bench/r5p_trace_tb.sv ====
// needs --timing and --assert in Verilator; fixed seed, the run stops at the first mismatch
`timescale 1ns/1ps

module r5p_trace_tb
    import trace_pkg::*;
();

    ////////////////////
    // run setup
    ////////////////////

    localparam int unsigned SEED        = 32'he2958df9;
    localparam int          N_SINGLE    = 200;  // sparse fetches
    localparam int          N_B2B       = 300;  // back-to-back fetches
    localparam int          N_EMPTY     = 6;    // pops on an empty buffer
    localparam int          N_FLOOD     = 40;   // fetches with pops withheld
    localparam int          TIMEOUT_CYC = 2 + N_SINGLE + N_B2B + N_EMPTY + N_FLOOD + 100;

    // phase codes, traffic phases first
    localparam int M_SINGLE   = 0;
    localparam int M_B2B      = 1;
    localparam int M_FLOOD    = 2;
    localparam int M_IDLE_POP = 3;
    localparam int M_DRAIN    = 4;

    logic            tcb_ifu;
    logic            rst_n;
    logic            ifu_vld;
    logic            ifu_rdy;
    logic [XLEN-1:0] ifu_adr;
    logic [XLEN-1:0] ifu_rdt;
    logic            lsu_vld;
    logic            lsu_rdy;
    logic            lsu_wen;
    logic [XLEN-1:0] lsu_adr;
    logic [     1:0] lsu_siz;
    logic [XLEN-1:0] lsu_wdt;
    logic [XLEN-1:0] lsu_rdt;
    logic            gpr_den;
    logic [GLOG-1:0] gpr_did;
    logic [XLEN-1:0] gpr_ddt;
    logic [GLOG-1:0] gpr_sid;
    logic            rec_pop;
    logic            rec_empty;
    trace_rec_t      rec_data;
    logic            ovf;

    r5p_trace_top i_dut (
        .tcb_ifu   (tcb_ifu),
        .rst_n     (rst_n),
        .ifu_vld   (ifu_vld),
        .ifu_rdy   (ifu_rdy),
        .ifu_adr   (ifu_adr),
        .ifu_rdt   (ifu_rdt),
        .lsu_vld   (lsu_vld),
        .lsu_rdy   (lsu_rdy),
        .lsu_wen   (lsu_wen),
        .lsu_adr   (lsu_adr),
        .lsu_siz   (lsu_siz),
        .lsu_wdt   (lsu_wdt),
        .lsu_rdt   (lsu_rdt),
        .gpr_den   (gpr_den),
        .gpr_did   (gpr_did),
        .gpr_ddt   (gpr_ddt),
        .gpr_sid   (gpr_sid),
        .rec_pop   (rec_pop),
        .rec_empty (rec_empty),
        .rec_data  (rec_data),
        .ovf       (ovf)
    );

    initial begin
        tcb_ifu = 1'b0;
        forever #10 tcb_ifu = ~tcb_ifu;  // 20 ns period
    end

    ////////////////////
    // reference model state
    ////////////////////

    trace_rec_t      exp_q [$];       // expected buffer content, oldest first
    logic            m_ovf = 1'b0;
    logic            m_pnd = 1'b0;    // fetch transfer last cycle
    logic [XLEN-1:0] m_pnd_adr;
    logic            m_ret = 1'b0;    // record due this cycle
    logic [XLEN-1:0] m_ret_adr;
    logic [XLEN-1:0] m_ret_ins;
    logic            m_lsp = 1'b0;    // load/store transfer last cycle
    logic            m_lsp_wen;
    logic [GLOG-1:0] m_lsp_wid;
    logic [XLEN-1:0] m_lsp_adr;
    logic [     1:0] m_lsp_siz;
    logic [XLEN-1:0] m_lsp_wdt;
    int unsigned     cyc = 0;         // cycles since reset release
    int unsigned     cyc_total = 0;   // all cycles, for the timeout
    int unsigned     n_checked = 0;
    int unsigned     n_dropped = 0;

    ////////////////////
    // checks
    ////////////////////

    task automatic stop_run();
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Fail %0t ns %s: expected %0h, got %0h", $time, name, exp, got);
            stop_run();
        end
    endtask

    task automatic check_rec(input trace_rec_t got, input trace_rec_t exp);
        check_val("rec_data.tim",     32'(got.tim),     32'(exp.tim));
        check_val("rec_data.ifu_adr", 32'(got.ifu_adr), 32'(exp.ifu_adr));
        check_val("rec_data.ifu_ins", 32'(got.ifu_ins), 32'(exp.ifu_ins));
        check_val("rec_data.ifu_siz", 32'(got.ifu_siz), 32'(exp.ifu_siz));
        check_val("rec_data.ifu_ill", 32'(got.ifu_ill), 32'(exp.ifu_ill));
        check_val("rec_data.wbu_ena", 32'(got.wbu_ena), 32'(exp.wbu_ena));
        check_val("rec_data.wbu_idx", 32'(got.wbu_idx), 32'(exp.wbu_idx));
        check_val("rec_data.wbu_dat", 32'(got.wbu_dat), 32'(exp.wbu_dat));
        check_val("rec_data.lsu_ena", 32'(got.lsu_ena), 32'(exp.lsu_ena));
        check_val("rec_data.lsu_wen", 32'(got.lsu_wen), 32'(exp.lsu_wen));
        check_val("rec_data.lsu_wid", 32'(got.lsu_wid), 32'(exp.lsu_wid));
        check_val("rec_data.lsu_adr", 32'(got.lsu_adr), 32'(exp.lsu_adr));
        check_val("rec_data.lsu_siz", 32'(got.lsu_siz), 32'(exp.lsu_siz));
        check_val("rec_data.lsu_wdt", 32'(got.lsu_wdt), 32'(exp.lsu_wdt));
        check_val("rec_data.lsu_rdt", 32'(got.lsu_rdt), 32'(exp.lsu_rdt));
    endtask

    ////////////////////
    // model, called mid cycle with this cycle's inputs
    ////////////////////

    task automatic model_cycle();
        trace_rec_t e;
        // outputs first, they reflect state before this edge
        check_val("rec_empty", 32'(rec_empty), 32'(exp_q.size() == 0));
        check_val("ovf", 32'(ovf), 32'(m_ovf));
        if (rec_pop && exp_q.size() != 0) begin
            check_rec(rec_data, exp_q[0]);
            e = exp_q.pop_front();
            n_checked++;
        end
        // retire cycle t+2, fetch of t with load/store of t+1
        if (m_ret) begin
            e         = '0;
            e.tim     = TLEN'(cyc);
            e.ifu_adr = m_ret_adr;
            e.ifu_ins = m_ret_ins;
            e.ifu_siz = (m_ret_ins[1:0] == 2'b11);  // RVC otherwise
            e.ifu_ill = (m_ret_ins == 32'h0000_0000) || (m_ret_ins == 32'hffff_ffff);
            e.wbu_ena = gpr_den;
            if (gpr_den) begin
                e.wbu_idx = gpr_did;
                e.wbu_dat = gpr_ddt;
            end
            e.lsu_ena = m_lsp;
            if (m_lsp) begin
                e.lsu_wen = m_lsp_wen;
                e.lsu_wid = m_lsp_wid;
                e.lsu_adr = m_lsp_adr;
                e.lsu_siz = m_lsp_siz;
                e.lsu_wdt = m_lsp_wdt;
                e.lsu_rdt = lsu_rdt;  // response now
            end
            if (exp_q.size() < int'(TRACE_DEPTH)) begin
                exp_q.push_back(e);  // pop above already made room
            end else begin
                m_ovf = 1'b1;
                n_dropped++;
            end
        end
        // pipeline advance, oldest stage first
        m_ret = m_pnd;
        if (m_pnd) begin
            m_ret_adr = m_pnd_adr;
            m_ret_ins = ifu_rdt;  // word of the previous fetch
        end
        m_pnd = ifu_vld & ifu_rdy;
        if (m_pnd) m_pnd_adr = ifu_adr;
        m_lsp = lsu_vld & lsu_rdy;
        if (m_lsp) begin
            m_lsp_wen = lsu_wen;
            m_lsp_wid = gpr_sid;
            m_lsp_adr = lsu_adr;
            m_lsp_siz = lsu_siz;
            m_lsp_wdt = lsu_wdt;
        end
        cyc++;
    endtask

    ////////////////////
    // stimulus
    ////////////////////

    task automatic drive_random(input int mode);
        int unsigned     sel;
        logic [XLEN-1:0] word;
        sel = $urandom % 8;
        case (sel)
            0:       word = '0;        // all zeros, illegal
            1:       word = '1;        // all ones, illegal
            default: word = $urandom;  // both sizes
        endcase
        case (mode)
            M_SINGLE: begin
                ifu_vld <= ($urandom % 4) == 0;
                ifu_rdy <= ($urandom % 4) != 0;
                rec_pop <= ($urandom % 4) != 0;
            end
            M_B2B: begin
                ifu_vld <= ($urandom % 8) != 0;
                ifu_rdy <= 1'b1;
                rec_pop <= 1'b1;  // often on an empty buffer
            end
            M_FLOOD: begin
                ifu_vld <= 1'b1;
                ifu_rdy <= 1'b1;
                rec_pop <= 1'b0;
            end
            default: begin
                ifu_vld <= 1'b0;
                ifu_rdy <= 1'b1;
                rec_pop <= (mode == M_IDLE_POP) || (($urandom % 4) != 0);
            end
        endcase
        ifu_adr <= $urandom & 32'hffff_fffe;  // halfword aligned PC
        ifu_rdt <= word;
        // loads and stores only in traffic phases
        lsu_vld <= (mode < M_IDLE_POP) && (($urandom % 2) == 0);
        lsu_rdy <= ($urandom % 4) != 0;
        lsu_wen <= ($urandom % 2) == 0;
        lsu_adr <= $urandom;
        lsu_siz <= 2'($urandom);
        lsu_wdt <= $urandom;
        lsu_rdt <= $urandom;
        gpr_den <= ($urandom % 2) == 0;
        gpr_did <= GLOG'($urandom);
        gpr_ddt <= $urandom;
        gpr_sid <= GLOG'($urandom);
    endtask

    task automatic step(input int mode);
        @(posedge tcb_ifu);
        drive_random(mode);
        @(negedge tcb_ifu);
        model_cycle();
    endtask

    // flush the pipe, then wait for the DUT to report empty
    task automatic drain_buffer(input int mode);
        repeat (3) step(mode);
        while (!rec_empty) step(mode);
    endtask

    always @(posedge tcb_ifu) begin
        cyc_total <= cyc_total + 1;
        if (cyc_total == TIMEOUT_CYC) begin
            $display("Timeout: run not finished after %0d cycles", TIMEOUT_CYC);
            stop_run();
        end
    end

    initial begin
        void'($urandom(SEED));
        rst_n   = 1'b0;
        ifu_vld = 1'b0;
        ifu_rdy = 1'b0;
        ifu_adr = '0;
        ifu_rdt = '0;
        lsu_vld = 1'b0;
        lsu_rdy = 1'b0;
        lsu_wen = 1'b0;
        lsu_adr = '0;
        lsu_siz = '0;
        lsu_wdt = '0;
        lsu_rdt = '0;
        gpr_den = 1'b0;
        gpr_did = '0;
        gpr_ddt = '0;
        gpr_sid = '0;
        rec_pop = 1'b0;
        repeat (2) @(posedge tcb_ifu);
        rst_n <= 1'b1;
        // cycle 0, buffer empty and no overflow yet
        @(negedge tcb_ifu);
        model_cycle();
        repeat (N_SINGLE) step(M_SINGLE);
        repeat (N_B2B) step(M_B2B);
        drain_buffer(M_IDLE_POP);
        repeat (N_EMPTY) step(M_IDLE_POP);  // pops while empty
        check_val("ovf", 32'(ovf), 32'(0));
        repeat (N_FLOOD) step(M_FLOOD);
        check_val("ovf", 32'(ovf), 32'(1));
        drain_buffer(M_DRAIN);             // survivors oldest first
        check_val("ovf", 32'(ovf), 32'(1));  // still sticky
        assert (n_dropped > 0) else begin
            $display("overflow phase dropped no records");
            stop_run();
        end
        $display("records checked %0d, dropped %0d", n_checked, n_dropped);
        $display("NO ERRORS");
        $finish;
    end

endmodule : r5p_trace_tb

// ==== r5p_trace_top.f ====
hdl/trace_pkg.sv
hdl/tcb_mon_if.sv
hdl/fetch_align.sv
hdl/lsu_align.sv
hdl/trace_assemble.sv
hdl/trace_fifo.sv
hdl/r5p_trace_top.sv
bench/r5p_trace_tb.sv

// ==== Makefile ====
# Verilator flow for the trace recorder, every variable can be set on the command line

VERILATOR ?= verilator
FILELIST  ?= r5p_trace_top.f
TB_TOP    ?= r5p_trace_tb
RTL_TOP   ?= r5p_trace_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= NO ERRORS
VFLAGS    ?= --timing --assert

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
